// ==== source/dm_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug module interface types shared by the
// transport, the FIFOs and the debug register bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dm_pkg;

  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  // response codes carried back with every request
  localparam logic [1:0] RespSuccess = 2'd0;
  localparam logic [1:0] RespFailed  = 2'd2;

  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  // field order matches the dmi scan chain, op in the low bits
  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    logic [DmiDataWidth-1:0] data;
    dtm_op_e                 op;
  } dmi_req_t;

  typedef struct packed {
    logic [DmiDataWidth-1:0] data;
    logic [1:0]              resp;
  } dmi_resp_t;

  // sticky status reported in dmistat and the dmi op field
  typedef enum logic [1:0] {
    DMINoError       = 2'h0,
    DMIReservedError = 2'h1,
    DMIOPFailed      = 2'h2,
    DMIBusy          = 2'h3
  } dmi_error_e;

  typedef struct packed {
    logic [14:0] zero1;
    logic        dmireset;
    logic        zero0;
    logic [2:0]  idle;
    logic [1:0]  dmistat;
    logic [5:0]  abits;
    logic [3:0]  version;
  } dtmcs_t;

endpackage

// ==== source/jtag_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TAP controller states and instruction codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package jtag_pkg;

  localparam int unsigned IrLength = 5;

  // the sixteen states of the IEEE 1149.1 controller
  typedef enum logic [3:0] {
    TestLogicReset, RunTestIdle,
    SelectDrScan, CaptureDr, ShiftDr, Exit1Dr, PauseDr, Exit2Dr, UpdateDr,
    SelectIrScan, CaptureIr, ShiftIr, Exit1Ir, PauseIr, Exit2Ir, UpdateIr
  } tap_state_e;

  // risc-v debug transport instructions
  // any code not listed here falls back to bypass
  typedef enum logic [IrLength-1:0] {
    IDCODE = 5'h01,
    DTMCS  = 5'h10,
    DMI    = 5'h11,
    BYPASS = 5'h1f
  } ir_e;

endpackage

// ==== source/dmi_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMI request and response channels, valid/ready
// master sends requests, slave sends responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface dmi_if;
  import dm_pkg::*;

  // request channel
  dmi_req_t  req;
  logic      req_valid;
  logic      req_ready;

  // response channel
  dmi_resp_t resp;
  logic      resp_valid;
  logic      resp_ready;

  modport master (
    output req, req_valid, resp_ready,
    input  req_ready, resp, resp_valid
  );

  modport slave (
    input  req, req_valid, resp_ready,
    output req_ready, resp, resp_valid
  );

endinterface

// ==== source/dmi_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// valid/ready FIFO, payload type set by parameter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dmi_fifo #(
  parameter type         T     = logic,
  parameter int unsigned Depth = 2
) (
  input  logic tck_i,
  input  logic trst_ni,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  T                    mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  assign ready_o = (count_q != CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  // oldest entry is always on the output
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge tck_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== source/dmi_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request and response FIFOs between two DMI ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dmi_buffer #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic  tck_i,
  input  logic  trst_ni,
  dmi_if.slave  host,
  dmi_if.master dev
);
  import dm_pkg::*;

  // requests flow host to dev
  dmi_fifo #(
    .T     (dmi_req_t),
    .Depth (FifoDepth)
  ) i_req_fifo (
    .tck_i,
    .trst_ni,
    .data_i  (host.req),
    .valid_i (host.req_valid),
    .ready_o (host.req_ready),
    .data_o  (dev.req),
    .valid_o (dev.req_valid),
    .ready_i (dev.req_ready)
  );

  // responses flow dev back to host
  dmi_fifo #(
    .T     (dmi_resp_t),
    .Depth (FifoDepth)
  ) i_resp_fifo (
    .tck_i,
    .trst_ni,
    .data_i  (dev.resp),
    .valid_i (dev.resp_valid),
    .ready_o (dev.resp_ready),
    .data_o  (host.resp),
    .valid_o (host.resp_valid),
    .ready_i (host.resp_ready)
  );

endmodule

// ==== source/dmi_jtag_tap.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IEEE 1149.1 TAP with IDCODE, BYPASS and DTMCS
// the DMI data register lives outside, fed by the DR strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dmi_jtag_tap #(
  parameter logic [31:0] IdcodeValue = 32'h00000001
) (
  input  logic                 tck_i,
  input  logic                 trst_ni,
  input  logic                 tms_i,
  input  logic                 td_i,
  output logic                 td_o,
  output logic                 tdo_oe_o,
  // strobes for the external dmi register
  output logic                 test_logic_reset_o,
  output logic                 capture_dr_o,
  output logic                 shift_dr_o,
  output logic                 update_dr_o,
  output logic                 dmi_access_o,
  output logic                 dtmcs_select_o,
  output logic                 dmi_reset_o,
  input  dm_pkg::dmi_error_e   dmi_error_i,
  output logic                 dmi_tdi_o,
  input  logic                 dmi_tdo_i
);
  import jtag_pkg::*;
  import dm_pkg::*;

  tap_state_e state_d, state_q;

  logic [IrLength-1:0] ir_shift_q;
  ir_e                 ir_q;

  logic [31:0] idcode_q;
  logic        bypass_q;
  dtmcs_t      dtmcs_q;

  logic idcode_select;
  logic bypass_select;
  logic tdo_mux;

  // tms walks the controller on every rising edge
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      TestLogicReset: state_d = tms_i ? TestLogicReset : RunTestIdle;
      RunTestIdle:    state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectDrScan:   state_d = tms_i ? SelectIrScan   : CaptureDr;
      CaptureDr:      state_d = tms_i ? Exit1Dr        : ShiftDr;
      ShiftDr:        state_d = tms_i ? Exit1Dr        : ShiftDr;
      Exit1Dr:        state_d = tms_i ? UpdateDr       : PauseDr;
      PauseDr:        state_d = tms_i ? Exit2Dr        : PauseDr;
      Exit2Dr:        state_d = tms_i ? UpdateDr       : ShiftDr;
      UpdateDr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectIrScan:   state_d = tms_i ? TestLogicReset : CaptureIr;
      CaptureIr:      state_d = tms_i ? Exit1Ir        : ShiftIr;
      ShiftIr:        state_d = tms_i ? Exit1Ir        : ShiftIr;
      Exit1Ir:        state_d = tms_i ? UpdateIr       : PauseIr;
      PauseIr:        state_d = tms_i ? Exit2Ir        : PauseIr;
      Exit2Ir:        state_d = tms_i ? UpdateIr       : ShiftIr;
      UpdateIr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
      default:        state_d = TestLogicReset;
    endcase
  end

  assign test_logic_reset_o = (state_q == TestLogicReset);
  assign capture_dr_o       = (state_q == CaptureDr);
  assign shift_dr_o         = (state_q == ShiftDr);
  assign update_dr_o        = (state_q == UpdateDr);

  // data register selection by the current instruction
  assign idcode_select  = (ir_q == IDCODE);
  assign dtmcs_select_o = (ir_q == DTMCS);
  assign dmi_access_o   = (ir_q == DMI);
  assign bypass_select  = !(idcode_select || dtmcs_select_o || dmi_access_o);

  // dmireset only counts on the update of a DTMCS scan
  assign dmi_reset_o = update_dr_o && dtmcs_select_o && dtmcs_q.dmireset;
  assign dmi_tdi_o   = td_i;

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      state_q    <= TestLogicReset;
      ir_shift_q <= '0;
      ir_q       <= IDCODE;
      idcode_q   <= IdcodeValue;
      bypass_q   <= 1'b0;
      dtmcs_q    <= '0;
    end else begin
      state_q <= state_d;

      // instruction register, back to IDCODE in test-logic-reset
      if (state_q == TestLogicReset) begin
        ir_shift_q <= '0;
        ir_q       <= IDCODE;
      end else if (state_q == CaptureIr) begin
        // low bits 01 as 1149.1 requires
        ir_shift_q <= {{(IrLength-2){1'b0}}, 2'b01};
      end else if (state_q == ShiftIr) begin
        ir_shift_q <= {td_i, ir_shift_q[IrLength-1:1]};
      end else if (state_q == UpdateIr) begin
        ir_q <= ir_e'(ir_shift_q);
      end

      // data registers, lsb first
      if (capture_dr_o) begin
        idcode_q <= IdcodeValue;
        bypass_q <= 1'b0;
        dtmcs_q  <= '{
          zero1:    '0,
          dmireset: 1'b0,
          zero0:    1'b0,
          idle:     3'd5,
          dmistat:  dmi_error_i,
          abits:    6'(DmiAddrWidth),
          version:  4'd1
        };
      end else if (shift_dr_o) begin
        if (idcode_select) begin
          idcode_q <= {td_i, idcode_q[31:1]};
        end
        if (dtmcs_select_o) begin
          dtmcs_q <= dtmcs_t'({td_i, dtmcs_q[31:1]});
        end
        if (bypass_select) begin
          bypass_q <= td_i;
        end
      end
    end
  end

  // tdo source, ir while shifting ir, else the selected dr
  always_comb begin
    tdo_mux = bypass_q;
    if (state_q == ShiftIr) begin
      tdo_mux = ir_shift_q[0];
    end else begin
      unique case (ir_q)
        IDCODE:  tdo_mux = idcode_q[0];
        DTMCS:   tdo_mux = dtmcs_q[0];
        DMI:     tdo_mux = dmi_tdo_i;
        default: tdo_mux = bypass_q;
      endcase
    end
  end

  // tdo launches on the falling edge so the host samples a stable bit
  always_ff @(negedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      td_o     <= 1'b0;
      tdo_oe_o <= 1'b0;
    end else begin
      td_o     <= tdo_mux;
      tdo_oe_o <= (state_q == ShiftIr) || (state_q == ShiftDr);
    end
  end

endmodule

// ==== source/dmi_jtag.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// JTAG debug transport, turns DMI scans into requests
// and keeps the sticky busy / op-failed status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dmi_jtag #(
  parameter logic [31:0] IdcodeValue = 32'h00000001
) (
  input  logic   tck_i,
  input  logic   trst_ni,
  input  logic   tms_i,
  input  logic   td_i,
  output logic   td_o,
  output logic   tdo_oe_o,
  dmi_if.master  dmi
);
  import dm_pkg::*;

  typedef enum logic [2:0] {
    StIdle, StRead, StReadWait, StWrite, StWriteWait
  } state_e;

  localparam int unsigned DrWidth = $bits(dmi_req_t);

  logic test_logic_reset;
  logic capture_dr;
  logic shift_dr;
  logic update_dr;
  logic dmi_access;
  logic dtmcs_select;
  logic dmi_reset;
  logic dmi_tdi;
  logic dmi_tdo;

  state_e                  state_d, state_q;
  logic [DrWidth-1:0]      dr_d, dr_q;
  logic [DmiAddrWidth-1:0] address_d, address_q;
  logic [DmiDataWidth-1:0] data_d, data_q;
  dmi_error_e              error_d, error_q;
  logic                    busy;

  // scan chain seen as {address, data, op}
  dmi_req_t dr_req;
  assign dr_req = dmi_req_t'(dr_q);

  assign dmi.req = '{
    addr: address_q,
    data: data_q,
    op:   (state_q == StWrite) ? DTM_WRITE : DTM_READ
  };
  assign dmi.req_valid  = (state_q == StRead) || (state_q == StWrite);
  // only one request in flight, so any response can be taken at once
  assign dmi.resp_ready = 1'b1;

  always_comb begin
    state_d   = state_q;
    address_d = address_q;
    data_d    = data_q;
    error_d   = error_q;
    busy      = 1'b0;

    unique case (state_q)
      StIdle: begin
        // new scans are dropped while an error is sticky
        if (dmi_access && update_dr && error_q == DMINoError) begin
          address_d = dr_req.addr;
          data_d    = dr_req.data;
          if (dr_req.op == DTM_READ) begin
            state_d = StRead;
          end else if (dr_req.op == DTM_WRITE) begin
            state_d = StWrite;
          end
        end
      end
      StRead: begin
        if (dmi.req_ready) begin
          state_d = StReadWait;
        end
      end
      StWrite: begin
        if (dmi.req_ready) begin
          state_d = StWriteWait;
        end
      end
      StReadWait, StWriteWait: begin
        if (dmi.resp_valid) begin
          // read data goes back out on the next capture
          if (state_q == StReadWait) begin
            data_d = dmi.resp.data;
          end
          if (dmi.resp.resp == RespFailed && error_q == DMINoError) begin
            error_d = DMIOPFailed;
          end
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase

    // an update before the last access finished
    if (update_dr && dmi_access && state_q != StIdle) begin
      busy = 1'b1;
    end
    // a capture before read data came back
    if (capture_dr && dmi_access && (state_q == StRead || state_q == StReadWait)) begin
      busy = 1'b1;
    end
    if (busy) begin
      error_d = DMIBusy;
    end

    // dmireset from DTMCS clears whatever error is held
    if (dmi_reset && dtmcs_select) begin
      error_d = DMINoError;
    end
  end

  // dmi data register, status field reports the sticky error
  always_comb begin
    dr_d = dr_q;
    if (capture_dr && dmi_access) begin
      dr_d = {address_q, data_q, busy ? DMIBusy : error_q};
    end
    if (shift_dr && dmi_access) begin
      dr_d = {dmi_tdi, dr_q[DrWidth-1:1]};
    end
    if (test_logic_reset) begin
      dr_d = '0;
    end
  end

  assign dmi_tdo = dr_q[0];

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      state_q   <= StIdle;
      dr_q      <= '0;
      address_q <= '0;
      data_q    <= '0;
      error_q   <= DMINoError;
    end else begin
      state_q   <= state_d;
      dr_q      <= dr_d;
      address_q <= address_d;
      data_q    <= data_d;
      error_q   <= error_d;
    end
  end

  dmi_jtag_tap #(
    .IdcodeValue (IdcodeValue)
  ) i_dmi_jtag_tap (
    .tck_i,
    .trst_ni,
    .tms_i,
    .td_i,
    .td_o,
    .tdo_oe_o,
    .test_logic_reset_o (test_logic_reset),
    .capture_dr_o       (capture_dr),
    .shift_dr_o         (shift_dr),
    .update_dr_o        (update_dr),
    .dmi_access_o       (dmi_access),
    .dtmcs_select_o     (dtmcs_select),
    .dmi_reset_o        (dmi_reset),
    .dmi_error_i        (error_q),
    .dmi_tdi_o          (dmi_tdi),
    .dmi_tdo_i          (dmi_tdo)
  );

endmodule

// ==== source/dm_regfile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug register bank answering DMI reads and writes
// out of range addresses answer with failed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dm_regfile #(
  parameter int unsigned NumRegs = 16
) (
  input  logic tck_i,
  input  logic trst_ni,
  dmi_if.slave dmi
);
  import dm_pkg::*;

  localparam int unsigned IdxWidth = (NumRegs > 1) ? $clog2(NumRegs) : 1;

  logic [DmiDataWidth-1:0] regs_q [NumRegs];
  logic [IdxWidth-1:0]     idx;
  logic                    in_range;
  logic                    req_fire;
  dmi_resp_t               resp_d, resp_q;
  logic                    resp_valid_q;

  assign idx      = dmi.req.addr[IdxWidth-1:0];
  assign in_range = (dmi.req.addr < DmiAddrWidth'(NumRegs));

  // a held response blocks the next request
  assign dmi.req_ready  = !resp_valid_q;
  assign req_fire       = dmi.req_valid && dmi.req_ready;
  assign dmi.resp       = resp_q;
  assign dmi.resp_valid = resp_valid_q;

  always_comb begin
    resp_d.data = '0;
    resp_d.resp = RespSuccess;
    if (!in_range) begin
      resp_d.resp = RespFailed;
    end else if (dmi.req.op == DTM_READ) begin
      resp_d.data = regs_q[idx];
    end
  end

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
      resp_valid_q <= 1'b0;
    end else begin
      if (dmi.resp_valid && dmi.resp_ready) begin
        resp_valid_q <= 1'b0;
      end
      if (req_fire) begin
        resp_valid_q <= 1'b1;
        if (dmi.req.op == DTM_WRITE && in_range) begin
          regs_q[idx] <= dmi.req.data;
        end
      end
    end
  end

  // answer is captured with the request and held until taken
  always_ff @(posedge tck_i) begin
    if (req_fire) begin
      resp_q <= resp_d;
    end
  end

endmodule

// ==== source/dmi_jtag_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// JTAG debug transport top, pins in and out
// transport -> FIFO buffer -> debug register bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dmi_jtag_top #(
  parameter logic [31:0] IdcodeValue = 32'h00000001,
  parameter int unsigned FifoDepth   = 2,
  parameter int unsigned NumRegs     = 16
) (
  input  logic tck_i,
  input  logic trst_ni,
  input  logic tms_i,
  input  logic td_i,
  output logic td_o,
  output logic tdo_oe_o
);

  // transport side and register bank side of the buffer
  dmi_if host_dmi ();
  dmi_if dev_dmi ();

  dmi_jtag #(
    .IdcodeValue (IdcodeValue)
  ) i_dmi_jtag (
    .tck_i,
    .trst_ni,
    .tms_i,
    .td_i,
    .td_o,
    .tdo_oe_o,
    .dmi (host_dmi.master)
  );

  dmi_buffer #(
    .FifoDepth (FifoDepth)
  ) i_dmi_buffer (
    .tck_i,
    .trst_ni,
    .host (host_dmi.slave),
    .dev  (dev_dmi.master)
  );

  dm_regfile #(
    .NumRegs (NumRegs)
  ) i_dm_regfile (
    .tck_i,
    .trst_ni,
    .dmi (dev_dmi.slave)
  );

endmodule

// ==== tests/dmi_jtag_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMI handshake and TDO enable assertions
// bound into the top level, reports through $error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dmi_jtag_asserts (
  input logic                 tck_i,
  input logic                 trst_ni,
  input logic                 tdo_oe_i,
  input jtag_pkg::tap_state_e tap_state_i,
  dmi_if                      host,
  dmi_if                      dev
);
  import jtag_pkg::*;

  // requests taken from the transport minus responses handed back
  logic [1:0] in_flight_q;

  // failed assertions so far, summed into the testbench verdict
  int fail_count = 0;

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      in_flight_q <= '0;
    end else begin
      case ({host.req_valid && host.req_ready, host.resp_valid && host.resp_ready})
        2'b10:   in_flight_q <= in_flight_q + 2'd1;
        2'b01:   in_flight_q <= in_flight_q - 2'd1;
        default: in_flight_q <= in_flight_q;
      endcase
    end
  end

  host_req_hold: assert property (@(posedge tck_i) disable iff (!trst_ni)
    host.req_valid && !host.req_ready |=> host.req_valid && $stable(host.req))
    else begin
      fail_count++;
      $error("transport request dropped or changed before it was accepted");
    end

  dev_req_hold: assert property (@(posedge tck_i) disable iff (!trst_ni)
    dev.req_valid && !dev.req_ready |=> dev.req_valid && $stable(dev.req))
    else begin
      fail_count++;
      $error("buffered request dropped or changed before it was accepted");
    end

  dev_resp_hold: assert property (@(posedge tck_i) disable iff (!trst_ni)
    dev.resp_valid && !dev.resp_ready |=> dev.resp_valid && $stable(dev.resp))
    else begin
      fail_count++;
      $error("register bank response dropped or changed before it was taken");
    end

  host_resp_hold: assert property (@(posedge tck_i) disable iff (!trst_ni)
    host.resp_valid && !host.resp_ready |=> host.resp_valid && $stable(host.resp))
    else begin
      fail_count++;
      $error("buffered response dropped or changed before it was taken");
    end

  // output enable follows the state of the half cycle before
  tdo_oe_in_shift: assert property (@(posedge tck_i) disable iff (!trst_ni)
    tdo_oe_i |-> (tap_state_i == ShiftIr || tap_state_i == ShiftDr))
    else begin
      fail_count++;
      $error("tdo enabled outside the shift states");
    end

  single_outstanding: assert property (@(posedge tck_i) disable iff (!trst_ni)
    in_flight_q <= 2'd1)
    else begin
      fail_count++;
      $error("more than one request outstanding at the transport");
    end

endmodule

bind dmi_jtag_top dmi_jtag_asserts i_dmi_jtag_asserts (
  .tck_i       (tck_i),
  .trst_ni     (trst_ni),
  .tdo_oe_i    (tdo_oe_o),
  .tap_state_i (i_dmi_jtag.i_dmi_jtag_tap.state_q),
  .host        (host_dmi),
  .dev         (dev_dmi)
);

// ==== tests/tb_dmi_jtag.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the JTAG debug transport top
// bit-bangs the TAP pins and checks IDCODE, BYPASS,
// DTMCS and DMI register accesses against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_dmi_jtag;
  import dm_pkg::*;
  import jtag_pkg::*;

  localparam logic [31:0] Idcode = 32'h1beef001;
  // scans issued by all tests together, each well under 60 cycles
  localparam int NumScans = 78;

  logic tck_i;
  logic trst_ni;
  logic tms_i;
  logic td_i;
  logic td_o;
  logic tdo_oe_o;

  logic        tdo_seen;
  int          check_count;
  int          error_count;
  int          assert_fails;
  integer      seed;
  logic [31:0] ref_regs [16];
  logic [63:0] dout;
  logic [40:0] cap;
  logic [31:0] rnd;
  logic [31:0] data;
  logic [6:0]  addr;
  logic [6:0]  last_addr;

  dmi_jtag_top #(
    .IdcodeValue (Idcode),
    .FifoDepth   (2),
    .NumRegs     (16)
  ) i_dmi_jtag_top (
    .tck_i,
    .trst_ni,
    .tms_i,
    .td_i,
    .td_o,
    .tdo_oe_o
  );

  initial begin
    tck_i = 1'b0;
    forever #5 tck_i = ~tck_i;
  end

  // watchdog sized from the number of scans
  initial begin
    #(NumScans * 60 * 10);
    $display("timeout: the scans did not finish in %0d ns", NumScans * 60 * 10);
    $display("Testbench failed");
    $finish;
  end

  task automatic check_value(input string test_name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("ERROR %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
    end
  endtask

  // one tck cycle, td_o sampled before new pin values go out
  task automatic tck_cycle(input logic tms, input logic tdi);
    @(posedge tck_i);
    tdo_seen = td_o;
    tms_i <= tms;
    td_i  <= tdi;
  endtask

  // five cycles of tms high reach test-logic-reset from any state
  task automatic reset_tap();
    repeat (5) begin
      tck_cycle(1'b1, 1'b0);
    end
    tck_cycle(1'b0, 1'b0);
  endtask

  // starts in run-test-idle or update, ends in update plus idle cycles
  task automatic scan_register(input logic is_ir, input int len, input logic [63:0] din,
                               input int idle, output logic [63:0] dout_o);
    dout_o = '0;
    tck_cycle(1'b1, 1'b0);
    if (is_ir) begin
      tck_cycle(1'b1, 1'b0);
    end
    tck_cycle(1'b0, 1'b0);
    tck_cycle(1'b0, 1'b0);
    // tdo of bit i shows up one cycle after bit i goes out
    for (int i = 0; i < len; i++) begin
      tck_cycle(i == len - 1, din[i]);
      if (i > 0) begin
        dout_o[i-1] = tdo_seen;
      end
    end
    tck_cycle(1'b1, 1'b0);
    dout_o[len-1] = tdo_seen;
    repeat (idle) begin
      tck_cycle(1'b0, 1'b0);
    end
  endtask

  task automatic shift_ir(input logic [4:0] code);
    logic [63:0] unused;
    scan_register(1'b1, IrLength, {59'b0, code}, 1, unused);
  endtask

  task automatic shift_dr(input int len, input logic [63:0] din, output logic [63:0] dout_o);
    scan_register(1'b0, len, din, 1, dout_o);
  endtask

  // dmi chain is {addr, data, op}, op shifted first
  task automatic dmi_scan(input logic [6:0] a, input logic [31:0] d, input logic [1:0] op,
                          input int idle, output logic [40:0] cap_o);
    logic [63:0] raw;
    scan_register(1'b0, 41, {23'b0, a, d, op}, idle, raw);
    cap_o = raw[40:0];
  endtask

  initial begin
    trst_ni     = 1'b0;
    tms_i       = 1'b1;
    td_i        = 1'b0;
    check_count = 0;
    error_count = 0;
    seed        = 32'h43dffd2b;
    repeat (5) @(posedge tck_i);
    trst_ni <= 1'b1;

    // idcode is selected after reset, then bypass delays by one bit
    reset_tap();
    shift_dr(32, 64'h0, dout);
    check_value("idcode", Idcode, dout[31:0]);
    shift_ir(BYPASS);
    rnd = $random(seed);
    shift_dr(16, {48'b0, rnd[15:0]}, dout);
    check_value("bypass", {rnd[14:0], 1'b0}, dout[15:0]);

    // dtmcs fields: version [3:0], abits [9:4], dmistat [11:10]
    shift_ir(DTMCS);
    shift_dr(32, 64'h0, dout);
    check_value("dtmcs version", 4'd1, dout[3:0]);
    check_value("dtmcs abits", 6'd7, dout[9:4]);
    check_value("dtmcs dmistat", 2'd0, dout[11:10]);

    // write, read back, then a nop scan carries the read data
    shift_ir(DMI);
    for (int a = 0; a < 16; a++) begin
      data = $random(seed);
      dmi_scan(7'(a), data, DTM_WRITE, 5, cap);
      ref_regs[a] = data;
      dmi_scan(7'(a), 32'h0, DTM_READ, 5, cap);
      check_value("write status", 2'd0, cap[1:0]);
      dmi_scan(7'h0, 32'h0, DTM_NOP, 5, cap);
      check_value("read data", ref_regs[a], cap[33:2]);
      check_value("read status", 2'd0, cap[1:0]);
    end

    // out of range read sets a sticky op failed
    dmi_scan(7'd20, 32'h0, DTM_READ, 5, cap);
    dmi_scan(7'h0, 32'h0, DTM_NOP, 5, cap);
    check_value("op failed status", 2'd2, cap[1:0]);
    dmi_scan(7'h0, 32'h0, DTM_NOP, 5, cap);
    check_value("op failed sticky", 2'd2, cap[1:0]);
    shift_ir(DTMCS);
    shift_dr(32, 64'h0001_0000, dout);
    check_value("op failed dmistat", 2'd2, dout[11:10]);
    shift_ir(DMI);
    dmi_scan(7'h0, 32'h0, DTM_NOP, 5, cap);
    check_value("op failed cleared", 2'd0, cap[1:0]);

    // capture on the direct path comes too early and reports busy
    dmi_scan(7'd5, 32'h0, DTM_READ, 0, cap);
    dmi_scan(7'h0, 32'h0, DTM_NOP, 5, cap);
    check_value("busy status", 2'd3, cap[1:0]);
    dmi_scan(7'h0, 32'h0, DTM_NOP, 5, cap);
    check_value("busy sticky", 2'd3, cap[1:0]);
    shift_ir(DTMCS);
    shift_dr(32, 64'h0001_0000, dout);
    check_value("busy dmistat", 2'd3, dout[11:10]);
    shift_ir(DMI);
    dmi_scan(7'd5, 32'h0, DTM_READ, 5, cap);
    dmi_scan(7'h0, 32'h0, DTM_NOP, 5, cap);
    check_value("busy recovery data", ref_regs[5], cap[33:2]);
    check_value("busy recovery status", 2'd0, cap[1:0]);

    // back to back write and read, each capture holds the previous answer
    last_addr = '0;
    for (int k = 0; k < 4; k++) begin
      rnd  = $random(seed);
      addr = {3'b0, rnd[3:0]};
      data = $random(seed);
      dmi_scan(addr, data, DTM_WRITE, 5, cap);
      if (k > 0) begin
        check_value("stream read data", ref_regs[last_addr[3:0]], cap[33:2]);
        check_value("stream read status", 2'd0, cap[1:0]);
      end
      ref_regs[addr[3:0]] = data;
      dmi_scan(addr, 32'h0, DTM_READ, 5, cap);
      check_value("stream write status", 2'd0, cap[1:0]);
      last_addr = addr;
    end
    dmi_scan(7'h0, 32'h0, DTM_NOP, 5, cap);
    check_value("stream last data", ref_regs[last_addr[3:0]], cap[33:2]);
    check_value("stream last status", 2'd0, cap[1:0]);

    // protocol assertions in the bound checker count toward the verdict
    assert_fails = i_dmi_jtag_top.i_dmi_jtag_asserts.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/dm_pkg.sv
source/jtag_pkg.sv
source/dmi_if.sv
source/dmi_fifo.sv
source/dmi_buffer.sv
source/dmi_jtag_tap.sv
source/dmi_jtag.sv
source/dm_regfile.sv
source/dmi_jtag_top.sv
tests/dmi_jtag_asserts.sv
tests/tb_dmi_jtag.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dmi_jtag
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
	  echo "simulation did not pass, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
